// File: logic/mesh_cache_config.svh
// Geometry of the cache and its backing memory
// Word width, word address width, line count and words per line

`ifndef MESH_CACHE_CONFIG_SVH
`define MESH_CACHE_CONFIG_SVH

`define MC_DATA_WIDTH 32
`define MC_ADDR_WIDTH 8
// Direct mapped, so one line per set
`define MC_SETS 8
`define MC_BLOCK_WORDS 4

`endif

// File: logic/cache_pkg.sv
// Word, address and request types of the cache
// Controller state encoding

`include "mesh_cache_config.svh"

package cache_pkg;

  typedef logic [`MC_DATA_WIDTH-1:0] word_t;
  typedef logic [`MC_ADDR_WIDTH-1:0] addr_t;
  typedef logic [$clog2(`MC_BLOCK_WORDS)-1:0] offset_t;
  typedef logic [$clog2(`MC_SETS)-1:0] set_t;
  typedef logic [`MC_ADDR_WIDTH-$clog2(`MC_SETS)-$clog2(`MC_BLOCK_WORDS)-1:0] tag_t;

  typedef enum logic {
    LOAD  = 1'b0,
    STORE = 1'b1
  } cache_op_e;

  typedef struct packed {
    cache_op_e op;
    addr_t     addr;  // Splits as tag, set, offset from the top
    word_t     wdata;
  } cache_req_s;

  typedef enum logic [2:0] {
    IDLE, LOOKUP, EVICT_REQ, EVICT_DATA, FILL_REQ, FILL_DATA, RESPOND
  } cache_state_e;

endpackage

// File: logic/dma_pkg.sv
// DMA channel types shared by the cache and the backing memory
// Block address and command packet

`include "mesh_cache_config.svh"

package dma_pkg;

  // Tag and set of a line, the word offset dropped
  typedef logic [`MC_ADDR_WIDTH-$clog2(`MC_BLOCK_WORDS)-1:0] block_addr_t;

  typedef struct packed {
    logic        write_not_read;
    block_addr_t block_addr;
  } dma_pkt_s;

endpackage

// File: logic/cache_ctrl_fsm.sv
// Cache controller state machine
// Sequences lookup, write-back, fill and response

`timescale 1ns/1ps

module cache_ctrl_fsm (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 req_v_i,
  input  cache_pkg::cache_op_e req_op_i,
  input  logic                 hit_i,
  input  logic                 dirty_i,
  input  logic                 dma_pkt_yumi_i,
  input  logic                 dma_wdata_yumi_i,
  input  logic                 dma_rdata_v_i,
  input  logic                 last_word_i,
  input  logic                 resp_yumi_i,
  output logic                 req_ready_o,
  output logic                 lookup_o,
  output logic                 fill_we_o,
  output logic                 store_we_o,
  output logic                 evict_o,
  output logic                 dma_pkt_v_o,
  output logic                 dma_write_o,
  output logic                 dma_wdata_v_o,
  output logic                 cnt_start_o,
  output logic                 resp_v_o
);

  cache_pkg::cache_state_e state_q, state_d;
  cache_pkg::cache_op_e    op_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) state_q <= cache_pkg::IDLE;
    else           state_q <= state_d;
  end

  always_ff @(posedge clk_i) begin
    if (lookup_o) op_q <= req_op_i;  // Needed again after a fill
  end

  always_comb begin
    state_d       = state_q;
    req_ready_o   = 1'b0;
    lookup_o      = 1'b0;
    fill_we_o     = 1'b0;
    store_we_o    = 1'b0;
    evict_o       = 1'b0;
    dma_pkt_v_o   = 1'b0;
    dma_write_o   = 1'b0;
    dma_wdata_v_o = 1'b0;
    cnt_start_o   = 1'b0;
    resp_v_o      = 1'b0;
    unique case (state_q)
      cache_pkg::IDLE: begin
        req_ready_o = 1'b1;
        lookup_o    = req_v_i;
        if (req_v_i) state_d = cache_pkg::LOOKUP;
      end
      cache_pkg::LOOKUP: begin
        if (hit_i) begin
          store_we_o = (op_q == cache_pkg::STORE);
          state_d    = cache_pkg::RESPOND;
        end else if (dirty_i) begin
          state_d = cache_pkg::EVICT_REQ;  // Victim goes back to memory first
        end else begin
          state_d = cache_pkg::FILL_REQ;
        end
      end
      cache_pkg::EVICT_REQ: begin
        evict_o     = 1'b1;
        dma_pkt_v_o = 1'b1;
        dma_write_o = 1'b1;
        cnt_start_o = 1'b1;
        if (dma_pkt_yumi_i) state_d = cache_pkg::EVICT_DATA;
      end
      cache_pkg::EVICT_DATA: begin
        evict_o       = 1'b1;
        dma_wdata_v_o = 1'b1;
        if (dma_wdata_yumi_i && last_word_i) state_d = cache_pkg::FILL_REQ;
      end
      cache_pkg::FILL_REQ: begin
        dma_pkt_v_o = 1'b1;
        cnt_start_o = 1'b1;
        if (dma_pkt_yumi_i) state_d = cache_pkg::FILL_DATA;
      end
      cache_pkg::FILL_DATA: begin
        fill_we_o = dma_rdata_v_i;
        // Look up again so a store lands on the refilled line
        if (dma_rdata_v_i && last_word_i) state_d = cache_pkg::LOOKUP;
      end
      cache_pkg::RESPOND: begin
        resp_v_o = 1'b1;
        if (resp_yumi_i) state_d = cache_pkg::IDLE;
      end
      default: state_d = cache_pkg::IDLE;
    endcase
  end

  a_ready_resp_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(req_ready_o && resp_v_o));
  a_wdata_in_evict: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dma_wdata_v_o |-> state_q == cache_pkg::EVICT_DATA);

endmodule

// File: logic/dma_word_counter.sv
// Word index within one block transfer
// Flags the final word of the block

`timescale 1ns/1ps
`include "mesh_cache_config.svh"

module dma_word_counter (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               start_i,
  input  logic               step_i,
  output cache_pkg::offset_t offset_o,
  output logic               last_o
);

  logic [$bits(cache_pkg::offset_t):0] cnt_q;  // One extra bit marks a finished block

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i)    cnt_q <= '0;
    else if (start_i) cnt_q <= '0;
    else if (step_i)  cnt_q <= cnt_q + 1'b1;
  end

  assign offset_o = cnt_q[$bits(cache_pkg::offset_t)-1:0];
  assign last_o   = (cnt_q == ($bits(cnt_q))'(`MC_BLOCK_WORDS - 1));

  a_no_overrun: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    step_i |-> cnt_q < `MC_BLOCK_WORDS);

endmodule

// File: logic/cache_tag_data.sv
// Tag, valid, dirty and data arrays of the direct-mapped cache
// Hit detection, victim address and response word

`timescale 1ns/1ps
`include "mesh_cache_config.svh"

module cache_tag_data (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  cache_pkg::cache_req_s req_i,
  input  logic                  lookup_i,
  input  logic                  evict_i,
  input  logic                  fill_we_i,
  input  logic                  store_we_i,
  input  cache_pkg::offset_t    fill_offset_i,
  input  cache_pkg::word_t      fill_data_i,
  input  cache_pkg::offset_t    rd_offset_i,
  output logic                  hit_o,
  output logic                  dirty_o,
  output dma_pkg::block_addr_t  victim_addr_o,
  output cache_pkg::word_t      rd_data_o,
  output cache_pkg::word_t      resp_data_o
);

  cache_pkg::cache_req_s req_q;
  cache_pkg::tag_t       req_tag;
  cache_pkg::set_t       req_set;
  cache_pkg::offset_t    req_off;
  logic [`MC_SETS-1:0]   valid_q, dirty_q;
  cache_pkg::tag_t       tag_mem  [`MC_SETS];
  cache_pkg::word_t      data_mem [`MC_SETS][`MC_BLOCK_WORDS];
  logic                  fill_last;

  assign {req_tag, req_set, req_off} = req_q.addr;
  assign fill_last = fill_we_i && (fill_offset_i == cache_pkg::offset_t'(`MC_BLOCK_WORDS - 1));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (fill_last) begin
      valid_q[req_set] <= 1'b1;  // Line is usable once the whole block is in
      dirty_q[req_set] <= 1'b0;
    end else if (store_we_i) begin
      dirty_q[req_set] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_i)   req_q <= req_i;
    if (fill_last)  tag_mem[req_set] <= req_tag;
    if (fill_we_i)  data_mem[req_set][fill_offset_i] <= fill_data_i;
    if (store_we_i) data_mem[req_set][req_off] <= req_q.wdata;
  end

  assign hit_o   = valid_q[req_set] && (tag_mem[req_set] == req_tag);
  assign dirty_o = valid_q[req_set] && dirty_q[req_set];

  // Old line's block while evicting, requested block for the fill
  assign victim_addr_o = evict_i ? {tag_mem[req_set], req_set} : {req_tag, req_set};
  assign rd_data_o     = data_mem[req_set][rd_offset_i];
  assign resp_data_o   = (req_q.op == cache_pkg::STORE) ? '0 : data_mem[req_set][req_off];

endmodule

// File: logic/dma_mem.sv
// Backing memory behind the DMA channel
// Serves block reads and writes one word per cycle

`timescale 1ns/1ps
`include "mesh_cache_config.svh"

module dma_mem (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  dma_pkg::dma_pkt_s pkt_i,
  input  logic              pkt_v_i,
  input  cache_pkg::word_t  wdata_i,
  input  logic              wdata_v_i,
  output logic              pkt_yumi_o,
  output cache_pkg::word_t  rdata_o,
  output logic              rdata_v_o,
  output logic              wdata_yumi_o
);

  typedef enum logic [1:0] {M_IDLE, M_ACCEPT, M_READ, M_WRITE} mem_state_e;

  mem_state_e           state_q;
  dma_pkg::block_addr_t blk_q;
  cache_pkg::offset_t   offset;
  logic                 last;
  cache_pkg::word_t     mem_q [2**`MC_ADDR_WIDTH];

  assign pkt_yumi_o   = (state_q == M_ACCEPT) && pkt_v_i;  // Packet waits one cycle
  assign rdata_v_o    = (state_q == M_READ);
  assign wdata_yumi_o = (state_q == M_WRITE) && wdata_v_i;
  assign rdata_o      = mem_q[{blk_q, offset}];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= M_IDLE;
      for (int i = 0; i < 2**`MC_ADDR_WIDTH; i++) mem_q[i] <= '0;
    end else begin
      unique case (state_q)
        M_IDLE:   if (pkt_v_i) state_q <= M_ACCEPT;
        M_ACCEPT: begin
          if (!pkt_v_i)                   state_q <= M_IDLE;
          else if (pkt_i.write_not_read) state_q <= M_WRITE;
          else                           state_q <= M_READ;
        end
        M_READ:   if (last) state_q <= M_IDLE;
        M_WRITE: begin
          if (wdata_yumi_o) mem_q[{blk_q, offset}] <= wdata_i;
          if (wdata_yumi_o && last) state_q <= M_IDLE;
        end
        default:  state_q <= M_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (pkt_yumi_o) blk_q <= pkt_i.block_addr;
  end

  dma_word_counter word_cnt (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .start_i  (pkt_yumi_o),
    .step_i   (rdata_v_o || wdata_yumi_o),
    .offset_o (offset),
    .last_o   (last)
  );

  a_no_wdata_in_read: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    state_q == M_READ |-> !wdata_v_i);

endmodule

// File: logic/mesh_cache_top.sv
// Cache slice top level
// Controller, block counter, arrays and backing memory

`timescale 1ns/1ps

module mesh_cache_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  cache_pkg::cache_req_s req_i,
  input  logic                  req_v_i,
  input  logic                  resp_yumi_i,
  output logic                  req_ready_o,
  output cache_pkg::word_t      resp_data_o,
  output logic                  resp_v_o
);

  logic hit, dirty, lookup, fill_we, store_we, evict, cnt_start, last_word;
  logic dma_pkt_v, dma_pkt_yumi, dma_write, dma_wdata_v, dma_wdata_yumi, dma_rdata_v;
  cache_pkg::offset_t   offset;
  cache_pkg::word_t     dma_rdata, dma_wdata;
  dma_pkg::block_addr_t block_addr;
  dma_pkg::dma_pkt_s    dma_pkt;

  assign dma_pkt = '{write_not_read: dma_write, block_addr: block_addr};

  cache_ctrl_fsm ctrl (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .req_v_i(req_v_i), .req_op_i(req_i.op),
    .hit_i(hit), .dirty_i(dirty), .dma_pkt_yumi_i(dma_pkt_yumi),
    .dma_wdata_yumi_i(dma_wdata_yumi), .dma_rdata_v_i(dma_rdata_v),
    .last_word_i(last_word), .resp_yumi_i(resp_yumi_i), .req_ready_o(req_ready_o),
    .lookup_o(lookup), .fill_we_o(fill_we), .store_we_o(store_we), .evict_o(evict),
    .dma_pkt_v_o(dma_pkt_v), .dma_write_o(dma_write), .dma_wdata_v_o(dma_wdata_v),
    .cnt_start_o(cnt_start), .resp_v_o(resp_v_o)
  );

  dma_word_counter block_cnt (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .start_i(cnt_start),
    .step_i((dma_wdata_v && dma_wdata_yumi) || dma_rdata_v),
    .offset_o(offset), .last_o(last_word)
  );

  cache_tag_data arrays (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .req_i(req_i), .lookup_i(lookup), .evict_i(evict),
    .fill_we_i(fill_we), .store_we_i(store_we), .fill_offset_i(offset),
    .fill_data_i(dma_rdata), .rd_offset_i(offset), .hit_o(hit), .dirty_o(dirty),
    .victim_addr_o(block_addr), .rd_data_o(dma_wdata), .resp_data_o(resp_data_o)
  );

  dma_mem mem (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .pkt_i(dma_pkt), .pkt_v_i(dma_pkt_v),
    .wdata_i(dma_wdata), .wdata_v_i(dma_wdata_v), .pkt_yumi_o(dma_pkt_yumi),
    .rdata_o(dma_rdata), .rdata_v_o(dma_rdata_v), .wdata_yumi_o(dma_wdata_yumi)
  );

endmodule

// File: tb/mesh_cache_tb.sv
// Testbench for the cache slice with a word-level reference model
// Directed and random requests, response back-pressure and a cycle timeout

`timescale 1ns/1ps

module mesh_cache_tb;

  localparam int SEED           = 50926;
  localparam int RESET_CYCLES   = 16;
  localparam int RAND_REQS      = 400;
  localparam int DIRECTED_REQS  = 16;
  localparam int MISS_BOUND     = 20;  // Dirty miss plus response and idle cycles
  localparam int MAX_STALL      = 3;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES +
                                  (RAND_REQS + DIRECTED_REQS) * (MISS_BOUND + MAX_STALL);

  logic                  clk_i = 1'b0;
  logic                  arst_n_i;
  cache_pkg::cache_req_s req_i;
  logic                  req_v_i;
  logic                  resp_yumi_i;
  logic                  req_ready_o;
  cache_pkg::word_t      resp_data_o;
  logic                  resp_v_o;

  cache_pkg::word_t model [256];  // Expected memory contents by word address
  int               cycle_count = 0;

  mesh_cache_top dut0 (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .req_v_i     (req_v_i),
    .resp_yumi_i (resp_yumi_i),
    .req_ready_o (req_ready_o),
    .resp_data_o (resp_data_o),
    .resp_v_o    (resp_v_o)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Test failed");
      $fatal(1, "Run timed out after %0d cycles without finishing", cycle_count);
    end
  end

  task automatic compare_word(input string name, input cache_pkg::word_t expected,
                              input cache_pkg::word_t actual);
    assert (actual == expected) else begin
      $display("ERR %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "Value mismatch in %s", name);
    end
  endtask

  task automatic require(input logic cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      $display("Test failed");
      $fatal(1, "Protocol check failed");
    end
  endtask

  // One full request and response, with the response held back for stall cycles
  task automatic transact(input string name, input cache_pkg::cache_op_e op,
                          input cache_pkg::addr_t addr, input cache_pkg::word_t wdata,
                          input int stall, output int latency);
    cache_pkg::word_t expected;
    expected = (op == cache_pkg::STORE) ? '0 : model[addr];
    require(req_ready_o, "Cache is not ready for a new request while idle");
    req_i   = '{op: op, addr: addr, wdata: wdata};
    req_v_i = 1'b1;
    @(negedge clk_i);  // Accepted at the rising edge just passed
    req_v_i = 1'b0;
    latency = 1;
    while (!resp_v_o) begin
      @(negedge clk_i);
      latency++;
    end
    require(!req_ready_o, "Cache is ready while a response is still pending");
    compare_word(name, expected, resp_data_o);
    repeat (stall) begin
      @(negedge clk_i);
      require(resp_v_o, "Response valid dropped while the response was withheld");
      compare_word("back_pressure", expected, resp_data_o);
      require(!req_ready_o, "Cache became ready while the response was withheld");
    end
    resp_yumi_i = 1'b1;
    @(negedge clk_i);
    resp_yumi_i = 1'b0;
    if (op == cache_pkg::STORE) model[addr] = wdata;
  endtask

  initial begin
    cache_pkg::word_t     first_word;
    cache_pkg::addr_t     addr;
    cache_pkg::cache_op_e op;
    int                   latency;
    arst_n_i    = 1'b0;
    req_i       = '0;
    req_v_i     = 1'b0;
    resp_yumi_i = 1'b0;
    void'($urandom(SEED));
    for (int i = 0; i < 256; i++) model[i] = '0;

    repeat (RESET_CYCLES) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    require(!resp_v_o, "Response valid is high right after reset");
    require(req_ready_o, "Cache is not ready right after reset");
    for (int i = 0; i < 8; i++) begin
      transact("reset_state", cache_pkg::LOAD, cache_pkg::addr_t'(i * 29 + 3), '0, 0, latency);
    end

    first_word = $urandom;
    transact("store_load", cache_pkg::STORE, 8'h47, first_word, 0, latency);
    transact("store_load", cache_pkg::LOAD, 8'h47, '0, 0, latency);

    // Same set 5 with tags 0 and 1, so the second store evicts the dirty first line
    first_word = $urandom;
    transact("conflict_eviction", cache_pkg::STORE, 8'h14, first_word, 0, latency);
    transact("conflict_eviction", cache_pkg::STORE, 8'h34, $urandom, 0, latency);
    transact("conflict_eviction", cache_pkg::LOAD, 8'h14, '0, 0, latency);

    transact("hit_latency", cache_pkg::STORE, 8'hA2, $urandom, 0, latency);
    transact("hit_latency", cache_pkg::LOAD, 8'hA3, '0, 0, latency);
    compare_word("hit_latency", 32'd2, cache_pkg::word_t'(latency));

    for (int i = 0; i < RAND_REQS; i++) begin
      addr = cache_pkg::addr_t'($urandom_range(0, 255));
      op   = cache_pkg::cache_op_e'($urandom_range(0, 1));
      transact("random_mix", op, addr, $urandom, int'($urandom_range(0, MAX_STALL)), latency);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: mesh_cache.f
+incdir+logic
logic/cache_pkg.sv
logic/dma_pkg.sv
logic/cache_ctrl_fsm.sv
logic/dma_word_counter.sv
logic/cache_tag_data.sv
logic/dma_mem.sv
logic/mesh_cache_top.sv
tb/mesh_cache_tb.sv

// File: Makefile
# Verilator flow for the cache slice testbench

VERILATOR  := verilator
FLAGS      := --timing --assert
TOP        := mesh_cache_tb
FILELIST   := mesh_cache.f
BUILD_DIR  := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The binary exits with a failing status when the testbench stops on $fatal
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
